// File: vlog.f
hw/fpu_pkg.sv
hw/fp_add.sv
hw/fp_mul.sv
hw/fp_compare.sv
hw/fcr_file.sv
hw/fpu.sv
hw/fp_exec_top.sv
test/fpu_tb.sv

// File: test/fpu_tb.sv
`timescale 1ns/10ps

module fpu_tb;
   import fpu_pkg::*;

   typedef struct packed {
      opcode_t    op;
      sp_word_t   a;
      sp_word_t   b;
      rob_ptr_t   rob;
      prf_ptr_t   dst;
      fcr_ptr_t   fcr_ptr;
      fcr_sel_t   fcr_sel;
      logic [3:0] idle;    // idle cycles before the row
      sp_word_t   exp_y;   // outcome bit in bit 0 for compares
   } row_t;

   typedef struct packed {
      logic [31:0] row;
      logic [31:0] cyc;    // cycle count when driven
      logic        is_cmp;
      sp_word_t    y;
      rob_ptr_t    rob;
      prf_ptr_t    dst;
      fcr_ptr_t    fcr_ptr;
   } expect_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        start;
   fpu_issue_t  issue;
   logic        val;
   logic        cmp_val;
   fpu_result_t result;

   row_t        rows [64];
   string       names [64];
   int          n_rows = 0;
   expect_t     exp_q [$];
   expect_t     done_e;
   fcr_t        fcr_model [16];
   logic [31:0] lcg_state = 32'hffca9c8e;
   int          cycles = 0;
   int          errors = 0;
   int          n_checks = 0;

   fp_exec_top dut0
   (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .issue   (issue),
      .val     (val),
      .cmp_val (cmp_val),
      .result  (result)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
      cycles <= cycles + 1;

   function automatic logic [31:0] next_random(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic is_compare(input opcode_t op);
      return (op == sp_cmp_lt) || (op == sp_cmp_eq) || (op == sp_cmp_le);
   endfunction

   task automatic check_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      n_checks++;
      if (actual !== expected)
      begin
         $display("error %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic add_row(input string name, input opcode_t op, input sp_word_t a,
                          input sp_word_t b, input int ptr, input int sel, input int idle,
                          input sp_word_t exp_y);
      lcg_state = next_random(lcg_state);
      names[n_rows] = name;
      rows[n_rows].op = op;
      rows[n_rows].a = a;
      rows[n_rows].b = b;
      rows[n_rows].rob = lcg_state[27:24];
      rows[n_rows].dst = lcg_state[19:16];
      rows[n_rows].fcr_ptr = fcr_ptr_t'(ptr);
      rows[n_rows].fcr_sel = fcr_sel_t'(sel);
      rows[n_rows].idle = 4'(idle);
      rows[n_rows].exp_y = exp_y;
      n_rows++;
   endtask

   task automatic issue_row(input int i);
      fcr_t    fcr_byte;
      expect_t e;
      if (rows[i].idle != 4'd0)
      begin
         start = 1'b0;
         issue = '0;
         for (int k = 0; k < rows[i].idle; k++)
            @(negedge clk);
      end
      start = 1'b1;
      issue.opcode = rows[i].op;
      issue.src_a = rows[i].a;
      issue.src_b = rows[i].b;
      issue.rob_ptr = rows[i].rob;
      issue.dst_ptr = rows[i].dst;
      issue.fcr_ptr = rows[i].fcr_ptr;
      issue.fcr_sel = rows[i].fcr_sel;
      if (rows[i].op != op_nop)
      begin
         e.row = i;
         e.cyc = cycles;
         e.is_cmp = is_compare(rows[i].op);
         e.rob = rows[i].rob;
         e.dst = rows[i].dst;
         e.fcr_ptr = rows[i].fcr_ptr;
         e.y = rows[i].exp_y;
         if (e.is_cmp)
         begin
            fcr_byte = fcr_model[rows[i].fcr_ptr];
            fcr_byte[rows[i].fcr_sel] = rows[i].exp_y[0];
            fcr_model[rows[i].fcr_ptr] = fcr_byte;
            e.y = {24'd0, fcr_byte};
         end
         exp_q.push_back(e);
      end
      @(negedge clk);
   endtask

   // outputs come from registers, so the falling edge sees them settled
   always @(negedge clk)
   begin
      if (val === 1'b1 && cmp_val === 1'b1)
      begin
         $display("val and cmp_val are both high at cycle %0d", cycles);
         errors++;
      end
      else if (reset === 1'b1)
      begin
         if (val !== 1'b0 || cmp_val !== 1'b0)
         begin
            $display("valid output seen during reset at cycle %0d", cycles);
            errors++;
         end
      end
      else if (val === 1'b1 || cmp_val === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("valid output at cycle %0d with no operation in flight", cycles);
            errors++;
         end
         else
         begin
            done_e = exp_q.pop_front();
            check_equal({names[done_e.row], " y"}, done_e.y, result.y);
            check_equal({names[done_e.row], " rob"}, done_e.rob, result.rob_ptr);
            check_equal({names[done_e.row], " dst"}, done_e.dst, result.dst_ptr);
            check_equal({names[done_e.row], " fcr_ptr"}, done_e.fcr_ptr, result.fcr_ptr);
            check_equal({names[done_e.row], " cmp_val"}, done_e.is_cmp, cmp_val);
            check_equal({names[done_e.row], " latency"}, 32'd2, cycles - done_e.cyc);
         end
      end
      else if ($isunknown({val, cmp_val}))
      begin
         $display("val or cmp_val is unknown at cycle %0d", cycles);
         errors++;
      end
   end

   initial
   begin
      reset = 1'b1;
      start = 1'b0;
      issue = '0;
      for (int i = 0; i < 16; i++)
         fcr_model[i] = 8'h00;

      // arithmetic, truncated toward zero
      add_row("add_3p0", sp_add, 32'h3f800000, 32'h40000000, 0, 0, 3, 32'h40400000);
      add_row("add_trunc", sp_add, 32'h3f800000, 32'h34400000, 1, 0, 1, 32'h3f800001);
      add_row("add_neg", sp_add, 32'hbfc00000, 32'h3f000000, 2, 0, 0, 32'hbf800000);
      add_row("sub_cancel", sp_sub, 32'h3f800000, 32'h3f800000, 0, 0, 1, 32'h00000000);
      add_row("sub_borrow", sp_sub, 32'h3f800000, 32'h33c00000, 0, 0, 0, 32'h3f7ffffe);
      add_row("add_ovf", sp_add, 32'h7f7fffff, 32'h7f7fffff, 0, 0, 1, 32'h7f800000);
      add_row("sub_inf_inf", sp_sub, 32'h7f800000, 32'h7f800000, 0, 0, 0, 32'h7fc00000);
      add_row("add_nan", sp_add, 32'h3f800000, 32'h7f800001, 0, 0, 0, 32'h7fc00000);
      add_row("mul_norm", sp_mul, 32'h3fc00000, 32'h3fc00000, 0, 0, 1, 32'h40100000);
      add_row("mul_6p0", sp_mul, 32'h40000000, 32'h40400000, 0, 0, 0, 32'h40c00000);
      add_row("mul_trunc", sp_mul, 32'h3f800001, 32'h3f800001, 0, 0, 0, 32'h3f800002);
      add_row("mul_uflow", sp_mul, 32'h8d800000, 32'h0d800000, 0, 0, 0, 32'h80000000);
      add_row("mul_ovf", sp_mul, 32'h7f000000, 32'hc0000000, 0, 0, 0, 32'hff800000);
      add_row("mul_inf_zero", sp_mul, 32'h7f800000, 32'h00000000, 0, 0, 0, 32'h7fc00000);
      add_row("mul_subnorm", sp_mul, 32'h00400000, 32'hc0000000, 0, 0, 0, 32'h80000000);
      add_row("nop", op_nop, 32'h3f800000, 32'h3f800000, 0, 0, 0, 32'h00000000);

      // same-fcr compares keep 2 idle cycles for the write-back
      add_row("cmp_lt_1_2", sp_cmp_lt, 32'h3f800000, 32'h40000000, 3, 0, 2, 32'd1);
      add_row("cmp_eq_pz_nz", sp_cmp_eq, 32'h00000000, 32'h80000000, 3, 1, 2, 32'd1);
      add_row("cmp_lt_nan", sp_cmp_lt, 32'h7fc00000, 32'h3f800000, 3, 2, 2, 32'd0);
      add_row("cmp_le_equal", sp_cmp_le, 32'h40000000, 32'h40000000, 3, 7, 2, 32'd1);
      add_row("cmp_lt_neg", sp_cmp_lt, 32'hc0000000, 32'hbf800000, 3, 4, 2, 32'd1);
      add_row("cmp_eq_nan", sp_cmp_eq, 32'h3f800000, 32'h7fc00000, 3, 0, 2, 32'd0);
      add_row("cmp_le_nz_pz", sp_cmp_le, 32'h80000000, 32'h00000000, 3, 2, 2, 32'd1);
      add_row("cmp_lt_pz_nz", sp_cmp_lt, 32'h00000000, 32'h80000000, 9, 5, 0, 32'd0);
      add_row("cmp_le_3_2", sp_cmp_le, 32'h40400000, 32'h40000000, 9, 6, 2, 32'd0);
      add_row("cmp_lt_neg_pos", sp_cmp_lt, 32'hbf800000, 32'h3f800000, 9, 3, 2, 32'd1);
      add_row("cmp_le_nan", sp_cmp_le, 32'h7fc00000, 32'h7fc00000, 3, 5, 0, 32'd0);
      add_row("cmp_eq_1_1", sp_cmp_eq, 32'h3f800000, 32'h3f800000, 3, 6, 2, 32'd1);

      // back to back burst
      add_row("burst_add", sp_add, 32'h40000000, 32'h40000000, 1, 0, 2, 32'h40800000);
      add_row("burst_mul", sp_mul, 32'h40400000, 32'h40400000, 2, 0, 0, 32'h41100000);
      add_row("burst_cmp_a", sp_cmp_lt, 32'h3f800000, 32'h40000000, 10, 0, 0, 32'd1);
      add_row("burst_sub", sp_sub, 32'h40400000, 32'h3f800000, 4, 0, 0, 32'h40000000);
      add_row("burst_cmp_b", sp_cmp_eq, 32'h40000000, 32'h3f800000, 11, 1, 0, 32'd0);
      add_row("burst_nop", op_nop, 32'h00000000, 32'h00000000, 0, 0, 0, 32'h00000000);
      add_row("burst_mul2", sp_mul, 32'hbf800000, 32'h40000000, 5, 0, 0, 32'hc0000000);
      add_row("burst_add2", sp_add, 32'h3f000000, 32'h3f000000, 6, 0, 0, 32'h3f800000);
      add_row("burst_cmp_c", sp_cmp_le, 32'h3f800000, 32'h3f800000, 10, 1, 0, 32'd1);

      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      for (int i = 0; i < n_rows; i++)
         issue_row(i);
      start = 1'b0;
      issue = '0;

      for (int t = 0; t < 20 && exp_q.size() > 0; t++)
         @(negedge clk);
      if (exp_q.size() > 0)
      begin
         $display("timeout: %0d results never arrived", exp_q.size());
         errors++;
      end
      for (int t = 0; t < 4; t++)
         @(negedge clk);   // catch stray valids

      $display("checks %0d, errors %0d", n_checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

// File: hw/fp_exec_top.sv
`timescale 1ns/10ps

module fp_exec_top
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  fpu_pkg::fpu_issue_t  issue,
   output logic                 val,
   output logic                 cmp_val,
   output fpu_pkg::fpu_result_t result
);
   import fpu_pkg::*;

   fcr_t src_fcr;   // old byte read at issue

   fcr_file fcr0
   (
      .clk     (clk),
      .reset   (reset),
      .rd_ptr  (issue.fcr_ptr),
      .rd_data (src_fcr),
      .wr_en   (cmp_val),
      .wr_ptr  (result.fcr_ptr),
      .wr_data (result.y[7:0])
   );

   fpu fpu0
   (
      .clk     (clk),
      .reset   (reset),
      .start   (start),
      .issue   (issue),
      .src_fcr (src_fcr),
      .val     (val),
      .cmp_val (cmp_val),
      .result  (result)
   );

endmodule

// File: hw/fpu.sv
`timescale 1ns/10ps

module fpu
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 start,
   input  fpu_pkg::fpu_issue_t  issue,
   input  fpu_pkg::fcr_t        src_fcr,
   output logic                 val,
   output logic                 cmp_val,
   output fpu_pkg::fpu_result_t result
);
   import fpu_pkg::*;

   typedef struct packed {
      opcode_t  opcode;
      rob_ptr_t rob_ptr;
      prf_ptr_t dst_ptr;
      fcr_ptr_t fcr_ptr;
      fcr_sel_t fcr_sel;
      fcr_t     fcr;
   } tag_stage_t;

   logic                         add_en;
   logic                         sub_mode;
   logic                         mul_en;
   fp_cmp_t                      cmp_type;

   logic [fpu_lat-1:0]           r_val;
   tag_stage_t [fpu_lat-1:0]     r_tag;   // index 0 is the completing stage

   sp_word_t                     add_y;
   sp_word_t                     mul_y;
   logic                         cmp_bit;
   fcr_t                         merged_fcr;

   always_comb
   begin
      add_en = 1'b0;
      sub_mode = 1'b0;
      mul_en = 1'b0;
      cmp_type = cmp_none;
      case (issue.opcode)
         sp_add:    add_en = 1'b1;
         sp_sub:
         begin
            add_en = 1'b1;
            sub_mode = 1'b1;
         end
         sp_mul:    mul_en = 1'b1;
         sp_cmp_lt: cmp_type = cmp_lt;
         sp_cmp_eq: cmp_type = cmp_eq;
         sp_cmp_le: cmp_type = cmp_le;
         default:   cmp_type = cmp_none;
      endcase
   end

   fp_add sa(.clk(clk), .en(start && add_en), .sub(sub_mode),
             .a(issue.src_a), .b(issue.src_b), .y(add_y));

   fp_mul sm(.clk(clk), .en(start && mul_en),
             .a(issue.src_a), .b(issue.src_b), .y(mul_y));

   fp_compare sc(.clk(clk), .en(start && (cmp_type != cmp_none)), .cmp_type(cmp_type),
                 .a(issue.src_a), .b(issue.src_b), .y(cmp_bit));

   always_ff @(posedge clk)
   begin
      if (reset)
         r_val <= '0;
      else
      begin
         r_val[fpu_lat-1] <= start && (issue.opcode != op_nop);
         for (int i = 0; i < fpu_lat - 1; i++)
            r_val[i] <= r_val[i+1];
      end
   end

   always_ff @(posedge clk)
   begin
      r_tag[fpu_lat-1] <= '{issue.opcode, issue.rob_ptr, issue.dst_ptr,
                            issue.fcr_ptr, issue.fcr_sel, src_fcr};
      for (int i = 0; i < fpu_lat - 1; i++)
         r_tag[i] <= r_tag[i+1];
   end

   always_comb
   begin
      merged_fcr = r_tag[0].fcr;
      merged_fcr[r_tag[0].fcr_sel] = cmp_bit;     // other seven bits kept
      result.rob_ptr = r_tag[0].rob_ptr;
      result.dst_ptr = r_tag[0].dst_ptr;
      result.fcr_ptr = r_tag[0].fcr_ptr;
      result.y = 32'd0;
      val = 1'b0;
      cmp_val = 1'b0;
      case (r_tag[0].opcode)
         sp_add, sp_sub:
         begin
            result.y = add_y;
            val = r_val[0];
         end
         sp_mul:
         begin
            result.y = mul_y;
            val = r_val[0];
         end
         sp_cmp_lt, sp_cmp_eq, sp_cmp_le:
         begin
            result.y = {24'd0, merged_fcr};
            cmp_val = r_val[0];
         end
         default:
            result.y = 32'd0;
      endcase
   end

   assert property (@(posedge clk) disable iff (reset) r_val[0] |-> $onehot({val, cmp_val}));

endmodule

// File: hw/fcr_file.sv
`timescale 1ns/10ps

module fcr_file
(
   input  logic              clk,
   input  logic              reset,
   input  fpu_pkg::fcr_ptr_t rd_ptr,
   output fpu_pkg::fcr_t     rd_data,
   input  logic              wr_en,
   input  fpu_pkg::fcr_ptr_t wr_ptr,
   input  fpu_pkg::fcr_t     wr_data
);
   import fpu_pkg::*;

   fcr_t regs [2**lg_fcr_width];

   assign rd_data = regs[rd_ptr];                 // no bypass from the write port

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 2**lg_fcr_width; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
      begin
         regs[wr_ptr] <= wr_data;
      end
   end

   assert property (@(posedge clk) disable iff (reset) wr_en |-> !$isunknown(wr_ptr));

endmodule

// File: hw/fp_compare.sv
`timescale 1ns/10ps

module fp_compare
(
   input  logic              clk,
   input  logic              en,
   input  fpu_pkg::fp_cmp_t  cmp_type,
   input  fpu_pkg::sp_word_t a,
   input  fpu_pkg::sp_word_t b,
   output logic              y
);
   import fpu_pkg::*;

   logic [30:0] mag_a;
   logic [30:0] mag_b;
   logic        nan_a;
   logic        nan_b;

   logic        r_en;
   fp_cmp_t     r_type;
   logic        r_unord;
   logic        r_sign_a;
   logic        r_sign_b;
   logic        r_mag_lt;
   logic        r_mag_eq;
   logic        r_both_zero;

   logic        is_eq;
   logic        is_lt;

   always_comb
   begin
      mag_a = (a[30:23] == 8'd0) ? 31'd0 : a[30:0];
      mag_b = (b[30:23] == 8'd0) ? 31'd0 : b[30:0];
      nan_a = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
      nan_b = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
   end

   always_ff @(posedge clk)
   begin
      r_en <= en;
      if (en)
      begin
         r_type <= cmp_type;
         r_unord <= nan_a | nan_b;
         r_sign_a <= a[31];
         r_sign_b <= b[31];
         r_mag_lt <= mag_a < mag_b;
         r_mag_eq <= mag_a == mag_b;
         r_both_zero <= (mag_a == 31'd0) && (mag_b == 31'd0);   // +0 == -0
      end
   end

   always_comb
   begin
      is_eq = r_both_zero || ((r_sign_a == r_sign_b) && r_mag_eq);
      if (r_both_zero)
         is_lt = 1'b0;
      else if (r_sign_a != r_sign_b)
         is_lt = r_sign_a;
      else if (r_sign_a)
         is_lt = !r_mag_lt && !r_mag_eq;           // both negative
      else
         is_lt = r_mag_lt;
   end

   always_ff @(posedge clk)
   begin
      if (r_en)
      begin
         case (r_type)
            cmp_lt:  y <= !r_unord && is_lt;
            cmp_eq:  y <= !r_unord && is_eq;
            cmp_le:  y <= !r_unord && (is_lt || is_eq);
            default: y <= 1'b0;
         endcase
      end
   end

endmodule

// File: hw/fp_mul.sv
`timescale 1ns/10ps

module fp_mul
(
   input  logic              clk,
   input  logic              en,
   input  fpu_pkg::sp_word_t a,
   input  fpu_pkg::sp_word_t b,
   output fpu_pkg::sp_word_t y
);
   import fpu_pkg::*;

   logic [7:0]        exp_a;
   logic [7:0]        exp_b;
   logic              zero_a;
   logic              zero_b;
   logic              nan_a;
   logic              nan_b;
   logic              inf_a;
   logic              inf_b;
   logic [23:0]       man_a;
   logic [23:0]       man_b;

   logic              r_en;
   logic              r_sign;
   logic signed [9:0] r_exp;
   logic [47:0]       r_prod;
   logic              r_nan;
   logic              r_inf;
   logic              r_zero;

   logic signed [9:0] exp_res;
   logic [22:0]       frac;

   always_comb
   begin
      exp_a = a[30:23];
      exp_b = b[30:23];
      zero_a = exp_a == 8'd0;                      // includes subnormals
      zero_b = exp_b == 8'd0;
      nan_a = (exp_a == 8'hff) && (a[22:0] != 23'd0);
      nan_b = (exp_b == 8'hff) && (b[22:0] != 23'd0);
      inf_a = (exp_a == 8'hff) && (a[22:0] == 23'd0);
      inf_b = (exp_b == 8'hff) && (b[22:0] == 23'd0);
      man_a = zero_a ? 24'd0 : {1'b1, a[22:0]};
      man_b = zero_b ? 24'd0 : {1'b1, b[22:0]};
   end

   always_ff @(posedge clk)
   begin
      r_en <= en;
      if (en)
      begin
         r_sign <= a[31] ^ b[31];
         r_exp <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd127;
         r_prod <= man_a * man_b;
         r_nan <= nan_a | nan_b | (inf_a & zero_b) | (inf_b & zero_a);
         r_inf <= inf_a | inf_b;
         r_zero <= zero_a | zero_b;
      end
   end

   always_comb
   begin
      exp_res = r_prod[47] ? (r_exp + 10'sd1) : r_exp;    // product in [1,4)
      frac = r_prod[47] ? r_prod[46:24] : r_prod[45:23];
   end

   always_ff @(posedge clk)
   begin
      if (r_en)
      begin
         if (r_nan)
            y <= qnan_value;
         else if (r_inf)
            y <= {r_sign, 8'hff, 23'd0};
         else if (r_zero)
            y <= {r_sign, 31'd0};
         else if (exp_res >= 10'sd255)
            y <= {r_sign, 8'hff, 23'd0};
         else if (exp_res <= 10'sd0)
            y <= {r_sign, 31'd0};                  // underflow flush
         else
            y <= {r_sign, exp_res[7:0], frac};
      end
   end

endmodule

// File: hw/fp_add.sv
`timescale 1ns/10ps

module fp_add
(
   input  logic              clk,
   input  logic              en,
   input  logic              sub,
   input  fpu_pkg::sp_word_t a,
   input  fpu_pkg::sp_word_t b,
   output fpu_pkg::sp_word_t y
);
   import fpu_pkg::*;

   logic        sign_a;
   logic        sign_b;
   logic [7:0]  exp_a;
   logic [7:0]  exp_b;
   logic [23:0] man_a;
   logic [23:0] man_b;
   logic        nan_a;
   logic        nan_b;
   logic        inf_a;
   logic        inf_b;
   logic        a_bigger;
   logic [7:0]  exp_diff;
   logic [23:0] man_small;
   logic [4:0]  shift_amt;
   logic [55:0] shift_wide;
   logic        spec;
   sp_word_t    spec_y;

   logic        r_en;
   logic        r_sign;
   logic        r_eff_sub;
   logic        r_zero_sign;
   logic [7:0]  r_exp;
   logic [25:0] r_man_big;    // mantissa, guard, sticky
   logic [25:0] r_man_small;
   logic        r_spec;
   sp_word_t    r_spec_y;

   logic [26:0]        sum;
   logic [4:0]         lz;
   logic [26:0]        norm;
   logic signed [9:0]  exp_res;
   sp_word_t           y_next;

   function automatic logic [4:0] lead_zeros(input logic [26:0] v);
      logic [4:0] n;
      logic       found;
      n = 5'd0;
      found = 1'b0;
      for (int i = 26; i >= 0; i--)
      begin
         if (v[i])
            found = 1'b1;
         else if (!found)
            n = n + 5'd1;
      end
      return n;
   endfunction

   always_comb
   begin
      sign_a = a[31];
      sign_b = b[31] ^ sub;                        // subtract flips b
      exp_a = a[30:23];
      exp_b = b[30:23];
      man_a = (exp_a == 8'd0) ? 24'd0 : {1'b1, a[22:0]};   // subnormal reads as zero
      man_b = (exp_b == 8'd0) ? 24'd0 : {1'b1, b[22:0]};
      nan_a = (exp_a == 8'hff) && (a[22:0] != 23'd0);
      nan_b = (exp_b == 8'hff) && (b[22:0] != 23'd0);
      inf_a = (exp_a == 8'hff) && (a[22:0] == 23'd0);
      inf_b = (exp_b == 8'hff) && (b[22:0] == 23'd0);
      a_bigger = {exp_a, man_a} >= {exp_b, man_b};
      exp_diff = a_bigger ? (exp_a - exp_b) : (exp_b - exp_a);
      man_small = a_bigger ? man_b : man_a;
      shift_amt = (exp_diff > 8'd31) ? 5'd31 : exp_diff[4:0];
      shift_wide = {man_small, 32'd0} >> shift_amt;
      spec = nan_a | nan_b | inf_a | inf_b;
      if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b)))
         spec_y = qnan_value;
      else if (inf_a)
         spec_y = {sign_a, 8'hff, 23'd0};
      else
         spec_y = {sign_b, 8'hff, 23'd0};
   end

   always_ff @(posedge clk)
   begin
      r_en <= en;
      if (en)
      begin
         r_sign <= a_bigger ? sign_a : sign_b;
         r_eff_sub <= sign_a != sign_b;
         r_zero_sign <= sign_a & sign_b;           // -0 only when both negative
         r_exp <= a_bigger ? exp_a : exp_b;
         r_man_big <= {(a_bigger ? man_a : man_b), 2'b00};
         r_man_small <= {shift_wide[55:31], |shift_wide[30:0]};
         r_spec <= spec;
         r_spec_y <= spec_y;
      end
   end

   always_comb
   begin
      if (r_eff_sub)
         sum = {1'b0, r_man_big} - {1'b0, r_man_small};
      else
         sum = {1'b0, r_man_big} + {1'b0, r_man_small};
      lz = lead_zeros(sum);
      norm = sum << lz;
      exp_res = $signed({2'b00, r_exp}) + 10'sd1 - $signed({5'd0, lz});
      if (r_spec)
         y_next = r_spec_y;
      else if (sum == 27'd0)
         y_next = {r_zero_sign, 31'd0};            // exact cancellation
      else if (exp_res >= 10'sd255)
         y_next = {r_sign, 8'hff, 23'd0};
      else if (exp_res <= 10'sd0)
         y_next = {r_sign, 31'd0};                 // flush to signed zero
      else
         y_next = {r_sign, exp_res[7:0], norm[25:3]};   // truncate
   end

   always_ff @(posedge clk)
   begin
      if (r_en)
         y <= y_next;
   end

   assert property (@(posedge clk) !$isunknown(en));

endmodule

// File: hw/fpu_pkg.sv
package fpu_pkg;

   localparam int fpu_lat      = 2;  // cycles from issue to result
   localparam int lg_rob_width = 4;
   localparam int lg_prf_width = 4;
   localparam int lg_fcr_width = 4;

   localparam logic [31:0] qnan_value = 32'h7fc00000;  // canonical quiet nan

   typedef logic [31:0]             sp_word_t;
   typedef logic [lg_rob_width-1:0] rob_ptr_t;
   typedef logic [lg_prf_width-1:0] prf_ptr_t;
   typedef logic [lg_fcr_width-1:0] fcr_ptr_t;
   typedef logic [7:0]              fcr_t;
   typedef logic [2:0]              fcr_sel_t;

   typedef enum logic [3:0] {
      op_nop    = 4'd0,
      sp_add    = 4'd1,
      sp_sub    = 4'd2,
      sp_mul    = 4'd3,
      sp_cmp_lt = 4'd4,
      sp_cmp_eq = 4'd5,
      sp_cmp_le = 4'd6
   } opcode_t;

   typedef enum logic [1:0] {
      cmp_none,
      cmp_lt,
      cmp_eq,
      cmp_le
   } fp_cmp_t;

   typedef struct packed {
      opcode_t  opcode;
      sp_word_t src_a;
      sp_word_t src_b;
      rob_ptr_t rob_ptr;
      prf_ptr_t dst_ptr;
      fcr_ptr_t fcr_ptr;
      fcr_sel_t fcr_sel;
   } fpu_issue_t;

   typedef struct packed {
      sp_word_t y;        // new fcr byte in low bits for compares
      rob_ptr_t rob_ptr;
      prf_ptr_t dst_ptr;
      fcr_ptr_t fcr_ptr;
   } fpu_result_t;

endpackage
